/* tests/frontend_trace.txt */
// @00 header {images, stimulus lines, expected}; @01 image {addr, word}
// @20 stimulus {repeat, ctrl, jump target, mtvec, mepc}; @40 expected {mis+class, pc, word}
@00
0F_11_14
@01
00000000_00100093
00000004_0000A103
00000008_0020A223
0000000C_00000063
00000010_0000006F
00000014_00000073
00000040_000011B7
00000044_FFFFFFFF
00000048_00208133
00000080_30200073
00000084_00000013
000000C0_0040A183
000000C4_0030A423
000000C8_FE000EE3
000000CC_000000E7
@20
04_01_00000000_00000000_00000000
01_03_00000000_00000000_00000000
02_01_00000000_00000000_00000000
01_05_00000042_00000000_00000000
03_01_00000000_00000000_00000000
01_09_00000000_00000080_00000000
02_01_00000000_00000000_00000000
01_25_00000040_00000000_000000C0
03_01_00000000_00000000_00000000
08_80_00000000_00000000_00000000
02_00_00000000_00000000_00000000
01_01_00000000_00000000_00000000
01_11_00000000_00000080_00000000
02_01_00000000_00000000_00000000
01_41_00000000_00000000_00000000
03_01_00000000_00000000_00000000
08_00_00000000_00000000_00000000
@40
0_00000000_00100093
1_00000004_0000A103
2_00000008_0020A223
3_0000000C_00000063
4_00000010_0000006F
5_00000014_00000073
8_00000040_000011B7
6_00000044_FFFFFFFF
0_00000048_00208133
5_00000080_30200073
0_00000084_00000013
1_000000C0_0040A183
2_000000C4_0030A423
3_000000C8_FE000EE3
4_000000CC_000000E7
5_00000080_30200073
0_00000084_00000013
0_00000000_00100093
1_00000004_0000A103
2_00000008_0020A223

/* build.f */
+incdir+src
src/frontend_pkg.sv
src/fetch_if.sv
src/fetch.sv
src/instr_mem.sv
src/issue_stage.sv
src/frontend_top.sv
tests/frontend_assertions.sv
tests/frontend_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module frontend_tb -Mdir obj_dir
	./obj_dir/Vfrontend_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TESTS FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* tests/frontend_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "frontend_defines.svh"

module frontend_tb;

    localparam int img_base  = 'h01;                // trace section offsets.
    localparam int stim_base = 'h20;
    localparam int exp_base  = 'h40;

    logic                    clk;
    logic                    reset_n;
    logic                    sys_reset;
    logic                    enable;
    logic                    jump;
    logic [31:0]             jump_target;
    logic [31:0]             mtvec;
    logic [31:0]             mepc;
    logic                    exception_raised;
    logic                    machine_return;
    logic                    interrupt_ack;
    logic                    hazard;
    logic                    load_en;
    logic [31:0]             load_addr;
    logic [31:0]             load_data;
    logic                    issue_valid;
    logic [31:0]             issue_pc;
    logic [31:0]             issue_instr;
    frontend_pkg::op_class_e issue_class;
    logic                    misaligned;

    logic [111:0] trace [0:127];                    // header, image, stimulus, expected.
    logic [111:0] entry;                            // expected entry under check.
    int           n_img;
    int           n_stim;
    int           n_exp;
    int           exp_idx = 0;                      // next expected issue.
    int           errors = 0;
    int           checks = 0;
    int           cycles = 0;
    int           limit = 0;                        // 0 until the trace is read.
    int           trace_len;

    frontend_top uut (
        .clk                (clk),
        .reset_n            (reset_n),
        .sys_reset_i        (sys_reset),
        .enable_i           (enable),
        .jump_i             (jump),
        .jump_target_i      (jump_target),
        .mtvec_i            (mtvec),
        .mepc_i             (mepc),
        .exception_raised_i (exception_raised),
        .machine_return_i   (machine_return),
        .interrupt_ack_i    (interrupt_ack),
        .hazard_i           (hazard),
        .load_en_i          (load_en),
        .load_addr_i        (load_addr),
        .load_data_i        (load_data),
        .issue_valid_o      (issue_valid),
        .issue_pc_o         (issue_pc),
        .issue_instr_o      (issue_instr),
        .issue_class_o      (issue_class),
        .misaligned_o       (misaligned)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                      // 4 ns period.
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // drives image line idx onto the load port or idles the port past the image.
    task automatic drive_load(input int idx);
        if (idx < n_img) begin
            load_en   = 1'b1;
            load_addr = trace[img_base + idx][63:32];
            load_data = trace[img_base + idx][31:0];
            if (load_addr[31:2] >= `FE_IMEM_WORDS) begin
                errors++;
                $display("image address %h lies outside the instruction memory", load_addr);
            end
        end else begin
            load_en = 1'b0;
        end
    endtask

    // ctrl bits from the lsb are enable, hazard, jump, exception, irq ack,
    // return, restart and random hazard.
    task automatic apply_stim(input logic [111:0] line);
        logic [7:0] ctrl;
        ctrl             = line[103:96];
        enable           = ctrl[0];
        hazard           = ctrl[7] ? 1'($urandom & 1) : ctrl[1];
        jump             = ctrl[2];
        exception_raised = ctrl[3];
        interrupt_ack    = ctrl[4];
        machine_return   = ctrl[5];
        sys_reset        = ctrl[6];
        jump_target      = line[95:64];
        mtvec            = line[63:32];
        mepc             = line[31:0];
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout after %0d cycles, %0d of %0d expected issues seen",
                     cycles, exp_idx, n_exp);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // outputs are stable mid cycle.
    always @(negedge clk) begin
        if (reset_n && issue_valid) begin
            if (exp_idx >= n_exp) begin
                errors++;
                $display("pc %h was issued after the expected list ran out", issue_pc);
            end else begin
                entry = trace[exp_base + exp_idx];
                check_value("issue_pc_o", issue_pc, entry[63:32]);
                check_value("issue_instr_o", issue_instr, entry[31:0]);
                check_value("issue_class_o", {29'd0, issue_class}, {29'd0, entry[66:64]});
                check_value("misaligned_o", {31'd0, misaligned}, {31'd0, entry[67]});
                exp_idx++;
            end
        end
    end

    initial begin
        int line;
        int rep;
        reset_n          = 1'b0;
        load_en          = 1'b0;
        load_addr        = '0;
        load_data        = '0;
        apply_stim('0);                             // everything idle.
        void'($urandom(18));
        $readmemh("tests/frontend_trace.txt", trace);
        n_img  = int'(trace[0][23:16]);
        n_stim = int'(trace[0][15:8]);
        n_exp  = int'(trace[0][7:0]);
        if (n_img > 16) begin
            errors++;
            $display("memory image has more lines than there are reset cycles");
        end
        trace_len = 0;
        for (line = 0; line < n_stim; line++) begin
            trace_len += int'(trace[stim_base + line][111:104]);
        end
        limit = 2 * trace_len + 50;
        drive_load(0);                              // written at the first edge.
        for (line = 1; line < 16; line++) begin
            @(posedge clk);
            #1;
            drive_load(line);
        end
        @(posedge clk);
        #1;
        load_en = 1'b0;
        reset_n = 1'b1;
        for (line = 0; line < n_stim; line++) begin
            for (rep = 0; rep < int'(trace[stim_base + line][111:104]); rep++) begin
                apply_stim(trace[stim_base + line]);
                @(posedge clk);
                #1;
            end
        end
        apply_stim('0);
        while (exp_idx < n_exp) begin
            @(posedge clk);                         // until every expected issue is seen.
        end
        repeat (4) @(posedge clk);                  // room for stray extra issues.
        $display("summary: %0d checks, %0d errors, %0d of %0d issues seen",
                 checks, errors, exp_idx, n_exp);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/frontend_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module frontend_assertions (
    input wire logic        clk,
    input wire logic        reset_n,
    input wire logic        sys_reset_i,
    input wire logic        jump_i,
    input wire logic        exception_raised_i,
    input wire logic        machine_return_i,
    input wire logic        interrupt_ack_i,
    input wire logic        issue_valid_o,
    input wire logic [31:0] issue_pc_o
);

    logic        redir;                             // any redirect input this cycle.
    logic        since_prev;                        // redirect since the last issue.
    logic        since_prev2;                       // redirect before the last issue.
    logic        prev_valid;                        // an issue was seen.
    logic [31:0] prev_pc;                           // pc of that issue.

    assign redir = sys_reset_i | jump_i | exception_raised_i
                 | machine_return_i | interrupt_ack_i;

    // the word fetched just before a redirect still issues once, so a
    // break in the pc sequence may show up two issues after the pulse.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            since_prev  <= 1'b1;
            since_prev2 <= 1'b1;
            prev_valid  <= 1'b0;
            prev_pc     <= '0;
        end else if (issue_valid_o) begin
            since_prev2 <= since_prev | redir;
            since_prev  <= redir;
            prev_valid  <= 1'b1;
            prev_pc     <= issue_pc_o;
        end else begin
            since_prev  <= since_prev | redir;
        end
    end

    quiet_in_reset: assert property (@(posedge clk) !reset_n |-> !issue_valid_o)
        else $error("issue_valid_o high while reset_n is low");

    pc_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        issue_valid_o |-> issue_pc_o[1:0] == 2'b00)
        else $error("issued pc %h is not word aligned", issue_pc_o);

    pc_steps_by_four: assert property (@(posedge clk) disable iff (!reset_n)
        issue_valid_o && prev_valid && !(since_prev2 || since_prev || redir)
        |-> issue_pc_o == prev_pc + 32'd4)
        else $error("issued pc %h does not follow %h", issue_pc_o, prev_pc);

    no_repeat: assert property (@(posedge clk) disable iff (!reset_n)
        issue_valid_o && $past(issue_valid_o) |-> issue_pc_o != $past(issue_pc_o))
        else $error("pc %h issued twice in a row", issue_pc_o);

endmodule

bind frontend_top frontend_assertions u_assert (
    .clk                (clk),
    .reset_n            (reset_n),
    .sys_reset_i        (sys_reset_i),
    .jump_i             (jump_i),
    .exception_raised_i (exception_raised_i),
    .machine_return_i   (machine_return_i),
    .interrupt_ack_i    (interrupt_ack_i),
    .issue_valid_o      (issue_valid_o),
    .issue_pc_o         (issue_pc_o)
);

`default_nettype wire

/* src/frontend_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "frontend_defines.svh"

module frontend_top (
    input  wire logic                 clk,
    input  wire logic                 reset_n,
    input  wire logic                 sys_reset_i,
    input  wire logic                 enable_i,
    input  wire logic                 jump_i,
    input  wire frontend_pkg::addr_t  jump_target_i,
    input  wire frontend_pkg::addr_t  mtvec_i,
    input  wire frontend_pkg::addr_t  mepc_i,
    input  wire logic                 exception_raised_i,
    input  wire logic                 machine_return_i,
    input  wire logic                 interrupt_ack_i,
    input  wire logic                 hazard_i,
    input  wire logic                 load_en_i,      // program load, before run.
    input  wire frontend_pkg::addr_t  load_addr_i,
    input  wire frontend_pkg::instr_t load_data_i,
    output logic                      issue_valid_o,
    output frontend_pkg::addr_t       issue_pc_o,
    output frontend_pkg::instr_t      issue_instr_o,
    output frontend_pkg::op_class_e   issue_class_o,
    output logic                      misaligned_o
);

    frontend_pkg::addr_t  imem_addr;                // fetch address.
    frontend_pkg::instr_t imem_data;                // word one edge later.

    fetch_if fe_bus ();

    fetch u_fetch (
        .clk                   (clk),
        .reset_n               (reset_n),
        .sys_reset_i           (sys_reset_i),
        .enable_i              (enable_i),
        .jump_i                (jump_i),
        .jump_target_i         (jump_target_i),
        .mtvec_i               (mtvec_i),
        .mepc_i                (mepc_i),
        .exception_raised_i    (exception_raised_i),
        .machine_return_i      (machine_return_i),
        .interrupt_ack_i       (interrupt_ack_i),
        .hazard_i              (hazard_i),
        .instruction_address_o (imem_addr),
        .fe                    (fe_bus.fetch_mp)
    );

    instr_mem #(
        .words (`FE_IMEM_WORDS)
    ) u_imem (
        .clk         (clk),
        .read_addr_i (imem_addr),
        .read_data_o (imem_data),
        .load_en_i   (load_en_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i)
    );

    issue_stage u_issue (
        .clk           (clk),
        .reset_n       (reset_n),
        .hazard_i      (hazard_i),
        .instr_i       (imem_data),
        .fe            (fe_bus.issue_mp),
        .issue_valid_o (issue_valid_o),
        .issue_pc_o    (issue_pc_o),
        .issue_instr_o (issue_instr_o),
        .issue_class_o (issue_class_o),
        .misaligned_o  (misaligned_o)
    );

endmodule

`default_nettype wire

/* src/issue_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module issue_stage (
    input  wire logic                 clk,
    input  wire logic                 reset_n,
    input  wire logic                 hazard_i,       // downstream busy, drop.
    input  wire frontend_pkg::instr_t instr_i,        // memory read data.
    fetch_if.issue_mp                 fe,
    output logic                      issue_valid_o,
    output frontend_pkg::addr_t       issue_pc_o,
    output frontend_pkg::instr_t      issue_instr_o,
    output frontend_pkg::op_class_e   issue_class_o,
    output logic                      misaligned_o    // with first word after redirect.
);

    frontend_pkg::tag_t          exp_tag;             // epoch of current words.
    frontend_pkg::filter_state_e state;
    frontend_pkg::filter_state_e state_nx;
    logic                        tag_ok;
    logic                        current;
    logic                        dup;
    logic                        keep;
    logic                        mis_pend;            // target flag not yet issued.
    logic                        mis_sel;

    function automatic frontend_pkg::op_class_e op_class(input logic [6:0] opcode);
        frontend_pkg::op_class_e cls;
        case (opcode)
            7'b0110011, 7'b0010011,
            7'b0110111, 7'b0010111: cls = frontend_pkg::op_alu;
            7'b0000011:             cls = frontend_pkg::op_load;
            7'b0100011:             cls = frontend_pkg::op_store;
            7'b1100011:             cls = frontend_pkg::op_branch;
            7'b1101111, 7'b1100111: cls = frontend_pkg::op_jump;
            7'b1110011:             cls = frontend_pkg::op_system;
            default:                cls = frontend_pkg::op_other;
        endcase
        return cls;
    endfunction

    // starts one behind fetch since reset acts as the first redirect.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            exp_tag <= '1;
        end else if (fe.jumped_r) begin
            exp_tag <= exp_tag + 1'b1;
        end
    end

    assign tag_ok  = (fe.tag == exp_tag);
    // the word arriving with jumped_r was fetched in the redirect cycle.
    assign current = (state != frontend_pkg::filt_idle) && !fe.jumped_r && tag_ok;
    assign dup     = (state == frontend_pkg::filt_pass) && (fe.pc == issue_pc_o);
    assign keep    = current && !hazard_i && !dup;
    assign mis_sel = fe.jumped ? fe.jump_misaligned : mis_pend;

    always_comb begin
        state_nx = state;
        if (fe.jumped_r) begin
            state_nx = frontend_pkg::filt_flush;    // any state.
        end else if (state == frontend_pkg::filt_flush && keep) begin
            state_nx = frontend_pkg::filt_pass;     // target issued.
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state         <= frontend_pkg::filt_idle;
            issue_valid_o <= 1'b0;
            misaligned_o  <= 1'b0;
            mis_pend      <= 1'b0;
        end else begin
            state         <= state_nx;
            issue_valid_o <= keep;
            if (keep) begin
                misaligned_o <= mis_sel;
                mis_pend     <= 1'b0;
            end else if (fe.jumped) begin
                mis_pend     <= fe.jump_misaligned;  // target dropped, keep flag.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (keep) begin
            issue_pc_o    <= fe.pc;
            issue_instr_o <= instr_i;
            issue_class_o <= op_class(instr_i[6:0]);
        end
    end

endmodule

`default_nettype wire

/* src/instr_mem.sv */
`timescale 1ns/100ps
`default_nettype none

`include "frontend_defines.svh"

module instr_mem #(
    parameter int unsigned words = `FE_IMEM_WORDS   // depth, power of two.
) (
    input  wire logic                 clk,
    input  wire frontend_pkg::addr_t  read_addr_i,  // byte address.
    output frontend_pkg::instr_t      read_data_o,  // one edge after the address.
    input  wire logic                 load_en_i,    // one word per cycle.
    input  wire frontend_pkg::addr_t  load_addr_i,  // byte address.
    input  wire frontend_pkg::instr_t load_data_i
);

    localparam int unsigned idx_w = $clog2(words);  // word index bits.

    frontend_pkg::instr_t mem [words];
    logic [idx_w-1:0]     read_idx;
    logic [idx_w-1:0]     load_idx;

    // drop byte offset, upper bits alias.
    assign read_idx = read_addr_i[idx_w+1:2];
    assign load_idx = load_addr_i[idx_w+1:2];

    always_ff @(posedge clk) begin
        if (load_en_i) begin
            mem[load_idx] <= load_data_i;           // program load.
        end
    end

    // registered read, plain block ram style.
    always_ff @(posedge clk) begin
        read_data_o <= mem[read_idx];
    end

endmodule

`default_nettype wire

/* src/fetch.sv */
`timescale 1ns/100ps
`default_nettype none

`include "frontend_defines.svh"

module fetch (
    input  wire logic                clk,
    input  wire logic                reset_n,
    input  wire logic                sys_reset_i,            // synchronous restart.
    input  wire logic                enable_i,               // level.
    input  wire logic                jump_i,                 // one-cycle pulse.
    input  wire frontend_pkg::addr_t jump_target_i,
    input  wire frontend_pkg::addr_t mtvec_i,                // trap vector.
    input  wire frontend_pkg::addr_t mepc_i,                 // saved exception pc.
    input  wire logic                exception_raised_i,
    input  wire logic                machine_return_i,
    input  wire logic                interrupt_ack_i,
    input  wire logic                hazard_i,               // level, holds fetch.
    output frontend_pkg::addr_t      instruction_address_o,  // to memory read port.
    fetch_if.fetch_mp                fe
);

    frontend_pkg::addr_t pc;                // next address to present.
    frontend_pkg::addr_t last_pc;           // last address actually presented.
    frontend_pkg::addr_t target_raw;        // redirect target before alignment.
    frontend_pkg::addr_t fetch_addr;        // address presented this cycle.
    frontend_pkg::tag_t  cur_tag;           // tag of the current redirect epoch.
    frontend_pkg::tag_t  last_tag;          // tag paired with last_pc.
    frontend_pkg::tag_t  fetch_tag;         // tag presented this cycle.
    logic                redirect;          // any redirect source this cycle.
    logic                jumped_r;          // redirect seen last cycle.
    logic                hold;              // re-present last address.
    logic                misaligned;        // flag that travels with pc.

    // any source that moves the pc somewhere other than pc + 4.
    assign redirect = sys_reset_i | machine_return_i | exception_raised_i
                    | interrupt_ack_i | jump_i;

    // right after a redirect the target is always presented once,
    // so hazard and enable only hold fetch from the second cycle on.
    assign hold = !jumped_r && (hazard_i || !enable_i);

    // redirect priority, restart first.
    always_comb begin
        if (sys_reset_i) begin
            target_raw = `FE_START_ADDRESS;
        end else if (machine_return_i) begin
            target_raw = mepc_i;                    // return beats trap and jump.
        end else if (exception_raised_i || interrupt_ack_i) begin
            target_raw = mtvec_i;
        end else begin
            target_raw = jump_target_i;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc         <= `FE_START_ADDRESS;
            misaligned <= 1'b0;
        end else if (redirect) begin
            pc         <= {target_raw[31:2], 2'b00};   // force word alignment.
            misaligned <= |target_raw[1:0];
        end else if (!hold) begin
            pc         <= pc + 32'd4;               // sequential step.
            misaligned <= 1'b0;
        end
    end

    // tag calculator, one new epoch per redirect.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cur_tag <= '0;
        end else if (redirect) begin
            cur_tag <= cur_tag + 1'b1;
        end
    end

    // replay copy for hazard and enable holds.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            last_pc  <= `FE_START_ADDRESS;
            last_tag <= '0;
        end else if (!hold) begin
            last_pc  <= pc;
            last_tag <= cur_tag;
        end
    end

    always_comb begin
        if (hold) begin
            fetch_addr = last_pc;                   // replay.
            fetch_tag  = last_tag;
        end else begin
            fetch_addr = pc;
            fetch_tag  = cur_tag;
        end
    end

    assign instruction_address_o = fetch_addr;

    // reset counts as a redirect so the start address is fetched at once
    // and the issue stage flushes whatever the memory held during reset.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            jumped_r           <= 1'b1;
            fe.jumped          <= 1'b1;
            fe.jump_misaligned <= 1'b0;
            fe.tag             <= '0;
        end else begin
            jumped_r           <= redirect;
            fe.jumped          <= jumped_r;         // target arrives now.
            fe.jump_misaligned <= misaligned;       // set only with the target.
            fe.tag             <= fetch_tag;
        end
    end

    // pc of the word on the memory read data next cycle.
    always_ff @(posedge clk) begin
        fe.pc <= fetch_addr;
    end

    assign fe.jumped_r = jumped_r;

endmodule

`default_nettype wire

/* src/fetch_if.sv */
`timescale 1ns/100ps
`default_nettype none

// fetch side info that travels one cycle behind the fetch address,
// lined up with the word the memory returns.
interface fetch_if;

    frontend_pkg::addr_t pc;                        // pc of the returned word.
    frontend_pkg::tag_t  tag;                       // tag of the returned word.
    logic                jumped;                    // redirect two cycles back.
    logic                jumped_r;                  // redirect one cycle back.
    logic                jump_misaligned;           // target had low bits set.

    modport fetch_mp (
        output pc, tag, jumped, jumped_r, jump_misaligned
    );

    modport issue_mp (
        input  pc, tag, jumped, jumped_r, jump_misaligned
    );

endinterface

`default_nettype wire

/* src/frontend_pkg.sv */
`default_nettype none

`include "frontend_defines.svh"

package frontend_pkg;

    typedef logic [31:0] addr_t;                    // byte address, pc.
    typedef logic [31:0] instr_t;                   // raw instruction word.
    typedef logic [`FE_TAG_WIDTH-1:0] tag_t;        // redirect epoch of a fetch.

    // coarse opcode classes seen by the issue stage.
    typedef enum logic [2:0] {
        op_alu,                                     // op, op-imm, lui, auipc.
        op_load,
        op_store,
        op_branch,
        op_jump,                                    // jal and jalr.
        op_system,
        op_other
    } op_class_e;

    typedef enum logic [1:0] {
        filt_idle,                                  // out of reset, nothing trusted yet.
        filt_pass,                                  // words issued since the last redirect.
        filt_flush                                  // redirect seen, waiting for the target.
    } filter_state_e;

endpackage

`default_nettype wire

/* src/frontend_defines.svh */
`ifndef FRONTEND_DEFINES_SVH
`define FRONTEND_DEFINES_SVH

// reset and restart address of the program counter.
`define FE_START_ADDRESS 32'h0000_0000

// instruction memory depth in 32-bit words.
`define FE_IMEM_WORDS 256

// fetch tag width, wraps freely.
`define FE_TAG_WIDTH 3

`endif
